/* Bender.yml */
package:
  name: uart

sources:
  - files:
      - verilog/uart_pkg.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_regs.sv
      - verilog/uart_top.sv
  - target: test
    files:
      - verification/uart_properties.sv
      - verification/uart_tb.sv

/* compile.f */
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
verification/uart_properties.sv
verification/uart_tb.sv

/* verification/uart_properties.sv */
// uart transmitter assertions
`timescale 1ns/100ps

module uart_properties (
    input logic                                      clk,
    input logic                                      rst_n,
    input uart_pkg::uart_tx_states_e                 state_i,
    input logic [uart_pkg::UART_FRAME_BIT_COUNT-1:0] bit_count_i,
    input logic                                      ready_i,
    input logic                                      tx_pin_i
);

    // line stays high while nothing is sent
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == uart_pkg::UART_TX_IDLE) |-> tx_pin_i)
        else $error("tx_pin_o low in IDLE");

    assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == uart_pkg::UART_TX_START) |=> !ready_i)
        else $error("ready_o still high after START");

    // ready returns only as the last stop bit ends
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready_i) |-> (state_i == uart_pkg::UART_TX_DATA) && tx_pin_i &&
                           ($past(bit_count_i) == uart_pkg::UART_FRAME_BIT_COUNT'(1)))
        else $error("ready_o rose before the frame ended");

    assert property (@(posedge clk) disable iff (!rst_n)
        state_i inside {uart_pkg::UART_TX_IDLE, uart_pkg::UART_TX_START,
                        uart_pkg::UART_TX_DATA})
        else $error("transmitter state outside its enum");

endmodule : uart_properties

bind uart_tx uart_properties i_uart_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .state_i     (state_ff),
    .bit_count_i (bit_count_ff),
    .ready_i     (ready_o),
    .tx_pin_i    (tx_pin_o)
);

/* verification/uart_tb.sv */
// uart peripheral testbench
`timescale 1ns/100ps

module uart_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_LOOP    = 12;               // random loopback frames
    localparam int MAX_DIV     = 16;
    localparam int NUM_FRAMES  = NUM_LOOP + 8;
    localparam int WATCHDOG_NS = NUM_FRAMES * 11 * MAX_DIV * CLK_PERIOD + 20000;
    localparam int MAX_POLLS   = 2000;

    logic                    clk;
    logic                    rst_n;
    logic                    rx_pin;
    logic                    tx_pin;
    logic                    irq;
    logic                    loop_sel;  // rx line follows tx when set
    logic                    drv_pin;
    logic [31:0]             bus_rdata;
    uart_pkg::uart_bus_req_t bus_req;

    // reference model
    uart_pkg::uart_cfg_t exp_cfg;
    logic [7:0]          sent_q[$];
    logic [7:0]          model_rx;
    integer              seed;

    uart_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .bus_rdata_o (bus_rdata),
        .rx_pin_i    (rx_pin),
        .tx_pin_o    (tx_pin),
        .irq_o       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        rx_pin <= loop_sel ? tx_pin : drv_pin;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "simulation timeout");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_stall(input string what);
        $display("%0t gave up waiting for %s after %0d status polls", $time, what, MAX_POLLS);
        $display("TB FAILED");
        $fatal(1, "handshake timeout");
    endtask

    function automatic int unsigned rand_div();
        return 2 + ($unsigned($random(seed)) % 14);  // 2 to 15
    endfunction

    task automatic bus_write(input uart_pkg::uart_reg_e reg_addr, input logic [31:0] data);
        @(posedge clk);
        bus_req <= '{wr: 1'b1, rd: 1'b0, addr: reg_addr, wdata: data};
        @(posedge clk);
        bus_req.wr <= 1'b0;
    endtask

    task automatic bus_read(input uart_pkg::uart_reg_e reg_addr, output logic [31:0] data);
        @(posedge clk);
        bus_req <= '{wr: 1'b0, rd: 1'b1, addr: reg_addr, wdata: '0};
        @(posedge clk);
        bus_req.rd <= 1'b0;
        @(negedge clk);
        data = bus_rdata;  // registered the edge before
    endtask

    // poll STATUS until every set_mask bit is 1 and every clr_mask bit is 0
    task automatic wait_status(input logic [31:0] set_mask, input logic [31:0] clr_mask,
                               input string what, output logic [31:0] status);
        int polls;
        polls = 0;
        bus_read(uart_pkg::UART_REG_STATUS, status);
        while (((status & set_mask) != set_mask) || ((status & clr_mask) != 0)) begin
            polls++;
            if (polls > MAX_POLLS) begin
                report_stall(what);
            end
            bus_read(uart_pkg::UART_REG_STATUS, status);
        end
    endtask

    task automatic set_config(input logic [15:0] div, input logic two_stop, input logic irq_en);
        exp_cfg = '{rx_irq_en: irq_en, two_stop: two_stop, baud_div: div};
        bus_write(uart_pkg::UART_REG_CTRL, 32'(exp_cfg));
    endtask

    // samples tx_pin_o at the centre of each bit-time
    task automatic check_frame(input logic [7:0] data, input logic two_stop,
                               input int unsigned div);
        logic [10:0] expected;
        int          nbits;
        expected = {2'b11, data, 1'b0};  // stop bits, data lsb first, start bit
        nbits    = two_stop ? 11 : 10;
        @(negedge clk);
        while (tx_pin !== 1'b0) begin
            @(negedge clk);
        end
        repeat (div / 2) @(negedge clk);
        for (int k = 0; k < nbits; k++) begin
            check_value($sformatf("tx_pin_o bit %0d", k), expected[k], tx_pin);
            repeat (div) @(negedge clk);
        end
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic stop_bit,
                               input int unsigned div);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            drv_pin <= bits[k];
            repeat (div - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_pin <= 1'b1;  // back to idle
    endtask

    task automatic send_byte(input logic [7:0] data);
        sent_q.push_back(data);
        fork
            bus_write(uart_pkg::UART_REG_DATA, {24'h0, data});
            check_frame(data, exp_cfg.two_stop, exp_cfg.baud_div);
        join
    endtask

    task automatic receive_byte();
        logic [31:0] status;
        logic [31:0] value;
        wait_status(32'h4, 32'h0, "rx_valid", status);
        check_value("STATUS[4:3]", 2'b00, status[4:3]);
        check_value("irq_o", exp_cfg.rx_irq_en, irq);
        model_rx = sent_q.pop_front();
        bus_read(uart_pkg::UART_REG_DATA, value);
        check_value("DATA", model_rx, value);
        check_value("irq_o", 1'b0, irq);  // rx_valid gone after the read
        wait_status(32'h1, 32'h2, "transmitter idle", status);
        check_value("STATUS", 32'h1, status);
    endtask

    initial begin
        logic [31:0] status;
        logic [31:0] value;
        logic [7:0]  first;
        logic [7:0]  second;
        seed     = 32'h822d5ed2;
        rst_n    = 1'b0;
        bus_req  = '0;
        rx_pin   = 1'b1;
        drv_pin  = 1'b1;
        loop_sel = 1'b1;
        exp_cfg  = '{rx_irq_en: 1'b0, two_stop: 1'b0, baud_div: 16'd16};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("tx_pin_o", 1'b1, tx_pin);
        check_value("irq_o", 1'b0, irq);
        bus_read(uart_pkg::UART_REG_STATUS, status);
        check_value("STATUS", 32'h1, status);
        bus_read(uart_pkg::UART_REG_CTRL, value);
        check_value("CTRL", 32'(exp_cfg), value);

        for (int i = 0; i < NUM_LOOP; i++) begin
            set_config(rand_div(), $random(seed), $random(seed));
            send_byte($random(seed));
            receive_byte();
        end

        // second write lands while tx_full is still set
        set_config(rand_div(), $random(seed), 1'b0);
        first  = $random(seed);
        second = $random(seed);
        sent_q.push_back(first);
        fork
            begin
                bus_write(uart_pkg::UART_REG_DATA, {24'h0, first});
                bus_write(uart_pkg::UART_REG_DATA, {24'h0, second});
            end
            check_frame(first, exp_cfg.two_stop, exp_cfg.baud_div);
        join
        receive_byte();
        send_byte($random(seed));
        receive_byte();

        // overrun, the second frame is dropped
        set_config(rand_div(), $random(seed), 1'b1);
        send_byte($random(seed));
        wait_status(32'h4, 32'h0, "rx_valid", status);
        send_byte($random(seed));
        model_rx = sent_q.pop_front();
        void'(sent_q.pop_front());
        wait_status(32'h8, 32'h0, "overrun", status);
        check_value("STATUS[4:2]", 3'b011, status[4:2]);
        check_value("irq_o", 1'b1, irq);
        bus_read(uart_pkg::UART_REG_STATUS, status);
        check_value("STATUS[4:2]", 3'b001, status[4:2]);
        bus_read(uart_pkg::UART_REG_DATA, value);
        check_value("DATA", model_rx, value);

        // driven frame with a low stop bit
        set_config(rand_div(), 1'b0, 1'b0);
        @(posedge clk);
        loop_sel <= 1'b0;
        model_rx = $random(seed);
        drive_frame(model_rx, 1'b0, exp_cfg.baud_div);
        wait_status(32'h4, 32'h0, "rx_valid", status);
        check_value("STATUS[4:2]", 3'b101, status[4:2]);
        bus_read(uart_pkg::UART_REG_STATUS, status);
        check_value("STATUS[4:2]", 3'b001, status[4:2]);
        bus_read(uart_pkg::UART_REG_DATA, value);
        check_value("DATA", model_rx, value);

        $display("TB PASSED");
        $finish;
    end

endmodule : uart_tb

/* verilog/uart_pkg.sv */
// uart shared definitions
package uart_pkg;

    // frame and bus sizes
    localparam int unsigned UART_DATA_SIZE       = 8;   // data bits per frame
    localparam int unsigned UART_BAUD_DIV_SIZE   = 16;  // clocks per bit, divisor width
    localparam int unsigned UART_FRAME_BIT_COUNT = 4;   // bit counter width
    localparam int unsigned UART_SBIT_DATA_SIZE  = 9;   // start bit plus data
    localparam int unsigned UART_BUS_WIDTH       = 32;  // register data width

    localparam logic [UART_FRAME_BIT_COUNT-1:0] UART_8DATA_1STOP_BITS = 4'd10;
    localparam logic [UART_FRAME_BIT_COUNT-1:0] UART_8DATA_2STOP_BITS = 4'd11;

    localparam logic [UART_BAUD_DIV_SIZE-1:0] UART_BAUD_DIV_RESET = 16'd16;  // divisor after reset

    typedef enum logic [1:0] {
        UART_TX_IDLE,
        UART_TX_START,  // loads shifter and bit counter
        UART_TX_DATA
    } uart_tx_states_e;

    typedef enum logic [1:0] {
        UART_RX_IDLE,
        UART_RX_START,  // waiting for mid start bit
        UART_RX_DATA,
        UART_RX_STOP
    } uart_rx_states_e;

    // register word offsets
    typedef enum logic [1:0] {
        UART_REG_DATA   = 2'd0,
        UART_REG_CTRL   = 2'd1,
        UART_REG_STATUS = 2'd2
    } uart_reg_e;

    // layout matches CTRL bits 17:0
    typedef struct packed {
        logic                          rx_irq_en;  // bit 17
        logic                          two_stop;   // bit 16
        logic [UART_BAUD_DIV_SIZE-1:0] baud_div;   // bits 15:0
    } uart_cfg_t;

    typedef struct packed {
        logic                      wr;     // single cycle write strobe
        logic                      rd;     // single cycle read strobe
        uart_reg_e                 addr;
        logic [UART_BUS_WIDTH-1:0] wdata;
    } uart_bus_req_t;

    typedef struct packed {
        logic [UART_DATA_SIZE-1:0] data;
        logic                      frame_err;  // first stop bit was low
    } uart_rx_byte_t;

endpackage : uart_pkg

/* verilog/uart_regs.sv */
// uart register block
`timescale 1ns/100ps

module uart_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  uart_pkg::uart_bus_req_t             bus_req_i,
    output logic [uart_pkg::UART_BUS_WIDTH-1:0] bus_rdata_o,  // valid the cycle after rd
    output uart_pkg::uart_cfg_t                 cfg_o,
    output logic [uart_pkg::UART_DATA_SIZE-1:0] tx_data_o,
    output logic                                tx_valid_o,
    input  logic                                tx_ready_i,
    input  logic                                rx_strobe_i,
    input  uart_pkg::uart_rx_byte_t             rx_byte_i,
    output logic                                irq_o
);

    uart_pkg::uart_cfg_t                 cfg_ff;
    logic [uart_pkg::UART_DATA_SIZE-1:0] tx_hold_ff;
    logic                                tx_full_ff;
    logic                                tx_ready_ff;
    logic [uart_pkg::UART_DATA_SIZE-1:0] rx_data_ff;
    logic                                rx_valid_ff;
    logic                                overrun_ff;
    logic                                frame_err_ff;
    logic [uart_pkg::UART_BUS_WIDTH-1:0] rdata_ff;
    logic [uart_pkg::UART_BUS_WIDTH-1:0] rdata_next;
    logic                                wr_data;
    logic                                wr_ctrl;
    logic                                rd_data;
    logic                                rd_status;
    logic                                tx_load;
    logic                                rx_store;

    assign wr_data   = bus_req_i.wr && (bus_req_i.addr == uart_pkg::UART_REG_DATA);
    assign wr_ctrl   = bus_req_i.wr && (bus_req_i.addr == uart_pkg::UART_REG_CTRL);
    assign rd_data   = bus_req_i.rd && (bus_req_i.addr == uart_pkg::UART_REG_DATA);
    assign rd_status = bus_req_i.rd && (bus_req_i.addr == uart_pkg::UART_REG_STATUS);
    assign tx_load   = wr_data && !tx_full_ff;      // dropped while holding register full
    assign rx_store  = rx_strobe_i && !rx_valid_ff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ff       <= '{rx_irq_en: 1'b0, two_stop: 1'b0,
                              baud_div: uart_pkg::UART_BAUD_DIV_RESET};
            tx_full_ff   <= 1'b0;
            tx_ready_ff  <= 1'b1;
            rx_valid_ff  <= 1'b0;
            overrun_ff   <= 1'b0;
            frame_err_ff <= 1'b0;
        end else begin
            tx_ready_ff <= tx_ready_i;
            if (wr_ctrl) begin
                cfg_ff <= bus_req_i.wdata[$bits(uart_pkg::uart_cfg_t)-1:0];
            end
            if (tx_load) begin
                tx_full_ff <= 1'b1;
            end else if (tx_ready_ff && !tx_ready_i) begin
                tx_full_ff <= 1'b0;  // transmitter has taken the byte
            end
            if (rd_data) begin
                rx_valid_ff <= 1'b0;
            end
            if (rd_status) begin
                overrun_ff   <= 1'b0;
                frame_err_ff <= 1'b0;
            end
            // a new event wins over a clear in the same cycle
            if (rx_strobe_i && rx_valid_ff) begin
                overrun_ff <= 1'b1;
            end
            if (rx_store) begin
                rx_valid_ff <= 1'b1;
                if (rx_byte_i.frame_err) begin
                    frame_err_ff <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_hold_ff <= bus_req_i.wdata[uart_pkg::UART_DATA_SIZE-1:0];
        end
        if (rx_store) begin
            rx_data_ff <= rx_byte_i.data;
        end
        if (bus_req_i.rd) begin
            rdata_ff <= rdata_next;
        end
    end

    always_comb begin
        rdata_next = '0;
        case (bus_req_i.addr)
            uart_pkg::UART_REG_DATA:   rdata_next[uart_pkg::UART_DATA_SIZE-1:0] = rx_data_ff;
            uart_pkg::UART_REG_CTRL:   rdata_next[$bits(uart_pkg::uart_cfg_t)-1:0] = cfg_ff;
            // frame_err, overrun, rx_valid, tx_full, tx_ready
            uart_pkg::UART_REG_STATUS: rdata_next[4:0] = {frame_err_ff, overrun_ff, rx_valid_ff,
                                                          tx_full_ff, tx_ready_i};
            default:                   rdata_next = '0;
        endcase
    end

    assign bus_rdata_o = rdata_ff;
    assign cfg_o       = cfg_ff;
    assign tx_data_o   = tx_hold_ff;
    assign tx_valid_o  = tx_full_ff;
    assign irq_o       = rx_valid_ff && cfg_ff.rx_irq_en;

endmodule : uart_regs

/* verilog/uart_rx.sv */
// uart serial receiver
`timescale 1ns/100ps

module uart_rx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rx_pin_i,     // asynchronous serial line
    input  uart_pkg::uart_cfg_t     cfg_i,
    output logic                    rx_strobe_o,  // one cycle per received frame
    output uart_pkg::uart_rx_byte_t rx_byte_o
);

    logic [1:0]                                sync_ff;  // two-flop synchronizer
    logic                                      rx_s;
    logic                                      rx_prev_ff;
    logic                                      start_edge;
    logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0]   sample_count_ff;
    logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0]   sample_count_next;
    logic [uart_pkg::UART_FRAME_BIT_COUNT-1:0] bit_count_ff;
    logic [uart_pkg::UART_FRAME_BIT_COUNT-1:0] bit_count_next;
    logic [uart_pkg::UART_DATA_SIZE-1:0]       data_ff;
    logic [uart_pkg::UART_DATA_SIZE-1:0]       data_next;
    logic                                      sample_pulse;
    logic                                      last_bit;
    logic                                      strobe_next;
    logic                                      strobe_ff;
    uart_pkg::uart_rx_byte_t                   rx_byte_ff;

    uart_pkg::uart_rx_states_e state_ff;
    uart_pkg::uart_rx_states_e state_next;

    assign rx_s         = sync_ff[1];
    assign start_edge   = rx_prev_ff && !rx_s;
    assign sample_pulse = (sample_count_ff == uart_pkg::UART_BAUD_DIV_SIZE'(1));
    assign last_bit     = (bit_count_ff ==
                           uart_pkg::UART_FRAME_BIT_COUNT'(uart_pkg::UART_DATA_SIZE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff         <= 2'b11;
            rx_prev_ff      <= 1'b1;
            state_ff        <= uart_pkg::UART_RX_IDLE;
            sample_count_ff <= '0;
            bit_count_ff    <= '0;
            strobe_ff       <= 1'b0;
        end else begin
            sync_ff         <= {sync_ff[0], rx_pin_i};
            rx_prev_ff      <= rx_s;
            state_ff        <= state_next;
            sample_count_ff <= sample_count_next;
            bit_count_ff    <= bit_count_next;
            strobe_ff       <= strobe_next;
        end
    end

    // shift register and delivered byte
    always_ff @(posedge clk) begin
        data_ff <= data_next;
        if (strobe_next) begin
            rx_byte_ff.data      <= data_ff;
            rx_byte_ff.frame_err <= !rx_s;  // only the first stop bit is checked
        end
    end

    always_comb begin
        state_next        = state_ff;
        sample_count_next = sample_count_ff - 1'b1;
        bit_count_next    = bit_count_ff;
        data_next         = data_ff;
        strobe_next       = 1'b0;

        case (state_ff)
            uart_pkg::UART_RX_IDLE: begin
                sample_count_next = cfg_i.baud_div >> 1;  // half a bit to the centre
                bit_count_next    = '0;
                if (start_edge) begin
                    state_next = uart_pkg::UART_RX_START;
                end
            end

            uart_pkg::UART_RX_START: begin
                if (sample_pulse) begin
                    sample_count_next = cfg_i.baud_div;
                    if (rx_s) begin
                        state_next = uart_pkg::UART_RX_IDLE;  // glitch, not a start bit
                    end else begin
                        state_next = uart_pkg::UART_RX_DATA;
                    end
                end
            end

            uart_pkg::UART_RX_DATA: begin
                if (sample_pulse) begin
                    sample_count_next = cfg_i.baud_div;
                    data_next         = {rx_s, data_ff[uart_pkg::UART_DATA_SIZE-1:1]};  // lsb first
                    bit_count_next    = bit_count_ff + 1'b1;
                    if (last_bit) begin
                        state_next = uart_pkg::UART_RX_STOP;
                    end
                end
            end

            uart_pkg::UART_RX_STOP: begin
                if (sample_pulse) begin
                    strobe_next = 1'b1;
                    state_next  = uart_pkg::UART_RX_IDLE;
                end
            end

            default: begin
                state_next = uart_pkg::UART_RX_IDLE;
            end
        endcase
    end

    assign rx_strobe_o = strobe_ff;
    assign rx_byte_o   = rx_byte_ff;

endmodule : uart_rx

/* verilog/uart_top.sv */
// uart peripheral top
`timescale 1ns/100ps

module uart_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  uart_pkg::uart_bus_req_t             bus_req_i,
    output logic [uart_pkg::UART_BUS_WIDTH-1:0] bus_rdata_o,
    input  logic                                rx_pin_i,
    output logic                                tx_pin_o,
    output logic                                irq_o
);

    uart_pkg::uart_cfg_t                 cfg;
    logic [uart_pkg::UART_DATA_SIZE-1:0] tx_data;
    logic                                tx_valid;
    logic                                tx_ready;
    logic                                rx_strobe;
    uart_pkg::uart_rx_byte_t             rx_byte;

    uart_regs i_uart_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req_i),
        .bus_rdata_o (bus_rdata_o),
        .cfg_o       (cfg),
        .tx_data_o   (tx_data),
        .tx_valid_o  (tx_valid),
        .tx_ready_i  (tx_ready),
        .rx_strobe_i (rx_strobe),
        .rx_byte_i   (rx_byte),
        .irq_o       (irq_o)
    );

    uart_tx i_uart_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_data_i (tx_data),
        .cfg_i     (cfg),
        .valid_i   (tx_valid),
        .ready_o   (tx_ready),
        .tx_pin_o  (tx_pin_o)
    );

    uart_rx i_uart_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_pin_i    (rx_pin_i),
        .cfg_i       (cfg),
        .rx_strobe_o (rx_strobe),
        .rx_byte_o   (rx_byte)
    );

endmodule : uart_top

/* verilog/uart_tx.sv */
// uart serial transmitter
`timescale 1ns/100ps

module uart_tx (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [uart_pkg::UART_DATA_SIZE-1:0] tx_data_i,  // held steady while valid_i
    input  uart_pkg::uart_cfg_t                 cfg_i,
    input  logic                                valid_i,
    output logic                                ready_o,
    output logic                                tx_pin_o
);

    logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0]   sample_count_ff;
    logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0]   sample_count_next;
    logic [uart_pkg::UART_FRAME_BIT_COUNT-1:0] bit_count_ff;
    logic [uart_pkg::UART_FRAME_BIT_COUNT-1:0] bit_count_next;
    logic [uart_pkg::UART_FRAME_BIT_COUNT-1:0] frame_size;
    logic [uart_pkg::UART_SBIT_DATA_SIZE-1:0]  shifter_ff;
    logic [uart_pkg::UART_SBIT_DATA_SIZE-1:0]  shifter_next;
    logic                                      sample_pulse;
    logic                                      tx_busy;
    logic                                      tx_pin_next;
    logic                                      tx_pin_ff;

    uart_pkg::uart_tx_states_e state_ff;
    uart_pkg::uart_tx_states_e state_next;

    // last cycle of a bit-time
    assign sample_pulse = (sample_count_ff == uart_pkg::UART_BAUD_DIV_SIZE'(1));
    assign tx_busy      = (bit_count_ff != '0);

    assign frame_size = cfg_i.two_stop ? uart_pkg::UART_8DATA_2STOP_BITS
                                       : uart_pkg::UART_8DATA_1STOP_BITS;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff        <= uart_pkg::UART_TX_IDLE;
            sample_count_ff <= '0;
            bit_count_ff    <= '0;
            shifter_ff      <= '1;
            tx_pin_ff       <= 1'b1;  // line idles high
        end else begin
            state_ff        <= state_next;
            sample_count_ff <= sample_count_next;
            bit_count_ff    <= bit_count_next;
            shifter_ff      <= shifter_next;
            tx_pin_ff       <= tx_pin_next;
        end
    end

    always_comb begin
        state_next        = state_ff;
        sample_count_next = cfg_i.baud_div;  // reloaded outside DATA
        bit_count_next    = bit_count_ff;
        shifter_next      = shifter_ff;
        tx_pin_next       = 1'b1;

        case (state_ff)
            uart_pkg::UART_TX_IDLE: begin
                if (valid_i && !tx_busy) begin
                    state_next = uart_pkg::UART_TX_START;
                end
            end

            uart_pkg::UART_TX_START: begin
                shifter_next   = {tx_data_i, 1'b0};  // start bit in lsb
                bit_count_next = frame_size;
                state_next     = uart_pkg::UART_TX_DATA;
            end

            uart_pkg::UART_TX_DATA: begin
                tx_pin_next = shifter_ff[0];
                if (sample_pulse) begin
                    bit_count_next    = bit_count_ff - 1'b1;
                    // ones shifted in become the stop bits
                    shifter_next      = {1'b1, shifter_ff[uart_pkg::UART_SBIT_DATA_SIZE-1:1]};
                    sample_count_next = cfg_i.baud_div;
                end else begin
                    sample_count_next = sample_count_ff - 1'b1;
                end
                if (!tx_busy) begin
                    state_next = uart_pkg::UART_TX_IDLE;
                end
            end

            default: begin
                state_next = uart_pkg::UART_TX_IDLE;
            end
        endcase
    end

    assign ready_o  = !tx_busy;
    assign tx_pin_o = tx_pin_ff;  // registered, one cycle behind the shifter

endmodule : uart_tx
